/* verilog.f */
verilog/ls_pkg.sv
verilog/mem_pkg.sv
verilog/ls_dcache.sv
verilog/ls_exec.sv
verilog/mem_ctrl.sv
verilog/byte_ram.sv
verilog/ls_unit.sv
test/tb_ls_unit.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing
TOP       := tb_ls_unit
RTL_TOP   := ls_unit
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_ls_unit.sv */
`timescale 1ns/1ps

module tb_ls_unit;

    localparam int CLK_NS       = 10;
    localparam int RESET_CYCLES = 10;
    localparam int POOL_WORDS   = 16;
    localparam int NUM_DIRECTED = 18;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_OPS      = POOL_WORDS + NUM_DIRECTED + NUM_RANDOM;
    // up to 20 cycles per operation, plus reset
    localparam int WATCHDOG_NS  = (NUM_OPS * 20 + RESET_CYCLES) * CLK_NS;

    logic            clk;
    logic            rst;
    logic            rdy;
    logic            ena;
    logic            rollback;
    ls_pkg::ls_req_t req;
    logic            busy;
    logic            valid;
    logic [31:0]     result;

    // flat byte model of the whole address space
    logic [7:0]  model [2**mem_pkg::MEM_ADDR_W];
    logic [31:0] lcg_state;
    logic        rdy_seen;
    logic        stalls_on;
    int          stall_left;
    int          errors;
    int          checks;

    ls_unit u_ls_unit (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .ena      (ena),
        .req      (req),
        .rollback (rollback),
        .busy     (busy),
        .valid    (valid),
        .result   (result)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'b0, lcg_state[30:15]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[15:0], lo[15:0]};
    endfunction

    // three tags over four lines, plus four I/O words
    function automatic logic [31:0] pool_addr(int k);
        if (k < 12) begin
            return 32'((k / 4) * 256 + (k % 4) * 4);
        end
        return ls_pkg::IO_BASE + 32'((k - 12) * 4);
    endfunction

    function automatic logic [31:0] predict_load(ls_pkg::ls_op_e op, logic [31:0] addr);
        logic [mem_pkg::MEM_ADDR_W-1:0] a;
        logic [31:0]                    w;
        a = addr[mem_pkg::MEM_ADDR_W-1:0];
        w = {model[a + 18'd3], model[a + 18'd2], model[a + 18'd1], model[a]};
        case (op)
            ls_pkg::op_lb:  return 32'($signed(w[7:0]));
            ls_pkg::op_lh:  return 32'($signed(w[15:0]));
            ls_pkg::op_lbu: return 32'(w[7:0]);
            ls_pkg::op_lhu: return 32'(w[15:0]);
            default:        return w;
        endcase
    endfunction

    task automatic apply_store(ls_pkg::ls_op_e op, logic [31:0] addr, logic [31:0] data);
        logic [mem_pkg::MEM_ADDR_W-1:0] a;
        int                             n;
        a = addr[mem_pkg::MEM_ADDR_W-1:0];
        n = (op == ls_pkg::op_sb) ? 1 : (op == ls_pkg::op_sh) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model[a + 18'(i)] = data[i*8 +: 8];
        end
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    // rising edge, then pick rdy for the next cycle
    task automatic advance();
        @(posedge clk);
        rdy_seen = rdy;
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            rdy <= 1'b0;
        end else if (stalls_on && next_random() % 16 == 0) begin
            stall_left = int'(next_random() % 4);
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    endtask

    task automatic sample_outputs();
        @(negedge clk);
        if (valid && !rdy) begin
            errors++;
            $display("error at %0t ns: valid pulsed while rdy was low", $time);
        end
    endtask

    task automatic run_op(ls_pkg::ls_op_e op, logic [31:0] addr, logic [31:0] data, logic rb);
        logic        is_load;
        logic        pending;
        logic [31:0] exp;
        int          quiet;
        is_load = !(op inside {ls_pkg::op_sb, ls_pkg::op_sh, ls_pkg::op_sw});
        exp = predict_load(op, addr);
        while (busy) begin
            advance();
            sample_outputs();
        end
        advance();
        ena         <= 1'b1;
        rollback    <= 1'b0;
        req.op      <= op;
        req.addr    <= addr;
        req.store_value <= data;
        sample_outputs();
        advance();
        while (!rdy_seen) begin
            sample_outputs();
            check_value("valid", 32'(valid), 32'd0);
            advance();
        end
        // taken on this edge
        ena      <= 1'b0;
        rollback <= rb;
        if (!is_load) begin
            apply_store(op, addr, data);
        end
        sample_outputs();
        pending = busy;
        if (is_load && rb && pending) begin
            // cancelled load, memory side still drains for size plus one cycles
            quiet = 0;
            while (quiet < 8) begin
                check_value("valid", 32'(valid), 32'd0);
                advance();
                if (rdy_seen) begin
                    rollback <= 1'b0;
                    quiet++;
                end
                sample_outputs();
            end
            check_value("valid", 32'(valid), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
        end else if (is_load) begin
            if (!pending && rdy) begin
                check_value("hit valid", 32'(valid), 32'd1);
            end
            while (!valid) begin
                advance();
                sample_outputs();
            end
            check_value("result", result, exp);
        end else begin
            while (busy) begin
                check_value("valid", 32'(valid), 32'd0);
                advance();
                sample_outputs();
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the operations did not finish within the time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0]    r;
        logic [31:0]    addr;
        ls_pkg::ls_op_e op;
        int             sel [3];
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        ena        = 1'b0;
        rollback   = 1'b0;
        req        = '0;
        lcg_state  = 32'd32786;
        stalls_on  = 1'b0;
        stall_left = 0;
        errors     = 0;
        checks     = 0;
        sel        = '{1, 6, 14};

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        sample_outputs();
        check_value("valid", 32'(valid), 32'd0);
        check_value("busy", 32'(busy), 32'd0);

        // defined contents for every pool word
        for (int k = 0; k < POOL_WORDS; k++) begin
            run_op(ls_pkg::op_sw, pool_addr(k), random_word(), 1'b0);
        end

        // byte and half merges on a cached, a bypassed and an I/O word
        foreach (sel[j]) begin
            addr = pool_addr(sel[j]);
            for (int b = 0; b < 4; b++) begin
                run_op(ls_pkg::op_sb, addr + 32'(b), random_word(), 1'b0);
            end
            run_op(ls_pkg::op_sh, addr + 32'd2, random_word(), 1'b0);
            run_op(ls_pkg::op_lw, addr, 32'd0, 1'b0);
        end

        stalls_on = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r    = next_random();
            op   = ls_pkg::ls_op_e'(4'(r % 8 + 1));
            addr = pool_addr(int'(next_random() % POOL_WORDS));
            r    = next_random();
            if (op inside {ls_pkg::op_lb, ls_pkg::op_lbu, ls_pkg::op_sb}) begin
                addr = addr + (r % 4);
            end else if (op inside {ls_pkg::op_lh, ls_pkg::op_lhu, ls_pkg::op_sh}) begin
                addr = addr + ((r % 2) * 2);
            end
            run_op(op, addr, random_word(), next_random() % 8 == 0);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/ls_unit.sv */
`timescale 1ns/1ps

module ls_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ena,
    input  ls_pkg::ls_req_t req,
    input  logic            rollback,
    output logic            busy,
    output logic            valid,
    output logic [31:0]     result
);

    logic                           store_en;
    logic                           read_hit;
    logic                           write_hit;
    logic [31:0]                    line;
    logic                           mem_ena;
    mem_pkg::mem_req_t              mem_req;
    logic                           mem_done;
    logic [31:0]                    mem_rdata;
    logic [mem_pkg::MEM_ADDR_W-1:0] ram_addr;
    logic                           ram_we;
    logic [7:0]                     ram_wdata;
    logic [7:0]                     ram_rdata;

    ls_exec u_ls_exec (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ena       (ena),
        .req       (req),
        .rollback  (rollback),
        .busy      (busy),
        .valid     (valid),
        .result    (result),
        .read_hit  (read_hit),
        .write_hit (write_hit),
        .line      (line),
        .store_en  (store_en),
        .mem_ena   (mem_ena),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    // lookup runs straight off the issue request
    ls_dcache u_ls_dcache (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .addr        (req.addr),
        .op          (req.op),
        .store_value (req.store_value),
        .store_en    (store_en),
        .read_hit    (read_hit),
        .write_hit   (write_hit),
        .line        (line)
    );

    mem_ctrl u_mem_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .mem_ena   (mem_ena),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    byte_ram u_byte_ram (
        .clk   (clk),
        .rdy   (rdy),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* verilog/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram (
    input  logic                           clk,
    input  logic                           rdy,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] addr,
    input  logic                           we,
    input  logic [7:0]                     wdata,
    output logic [7:0]                     rdata
);

    logic [7:0] mem [2**mem_pkg::MEM_ADDR_W];

    // registered read, both ports frozen by rdy
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

/* verilog/mem_ctrl.sv */
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          mem_ena,
    input  mem_pkg::mem_req_t             mem_req,
    output logic                          mem_done,
    output logic [31:0]                   mem_rdata,
    output logic [mem_pkg::MEM_ADDR_W-1:0] ram_addr,
    output logic                          ram_we,
    output logic [7:0]                    ram_wdata,
    input  logic [7:0]                    ram_rdata
);

    typedef enum logic [1:0] {
        idle,
        xfer,
        finish
    } state_e;

    state_e            state;
    mem_pkg::mem_req_t req_q;
    logic [2:0]        cnt;
    logic [1:0]        lane;
    logic              rd_arrive;

    // byte from the previous address arrives one cycle late
    assign lane      = 2'(cnt - 3'd1);
    assign rd_arrive = !req_q.write && ((state == xfer && cnt != 3'd0) || state == finish);

    assign ram_addr  = req_q.addr[mem_pkg::MEM_ADDR_W-1:0]
                     + {{(mem_pkg::MEM_ADDR_W-3){1'b0}}, cnt};
    assign ram_we    = (state == xfer) && req_q.write;
    assign ram_wdata = req_q.wdata[cnt[1:0]*8 +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            cnt      <= 3'd0;
            mem_done <= 1'b0;
        end else if (rdy) begin
            mem_done <= 1'b0;
            case (state)
                idle: begin
                    if (mem_ena) begin
                        cnt   <= 3'd0;
                        state <= xfer;
                    end
                end
                xfer: begin
                    cnt <= cnt + 3'd1;
                    if (cnt + 3'd1 == req_q.size) begin
                        state <= finish;
                    end
                end
                finish: begin
                    mem_done <= 1'b1;
                    state    <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // little-endian gather of read bytes
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == idle && mem_ena) begin
                req_q     <= mem_req;
                mem_rdata <= 32'b0;
            end else if (rd_arrive) begin
                mem_rdata[lane*8 +: 8] <= ram_rdata;
            end
        end
    end

endmodule

/* verilog/ls_exec.sv */
`timescale 1ns/1ps

module ls_exec (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ena,
    input  ls_pkg::ls_req_t   req,
    input  logic              rollback,
    output logic              busy,
    output logic              valid,
    output logic [31:0]       result,
    input  logic              read_hit,
    input  logic              write_hit,
    input  logic [31:0]       line,
    output logic              store_en,
    output logic              mem_ena,
    output mem_pkg::mem_req_t mem_req,
    input  logic              mem_done,
    input  logic [31:0]       mem_rdata
);

    typedef enum logic [1:0] {
        idle,
        wait_load,
        wait_store
    } state_e;

    state_e         state;
    ls_pkg::ls_op_e load_op;
    logic           valid_q;

    logic accept;
    logic is_load;
    logic is_store;
    logic cacheable;
    logic hit;

    // sign or zero extension of the low bytes
    function automatic logic [31:0] extend(ls_pkg::ls_op_e op, logic [31:0] w);
        case (op)
            ls_pkg::op_lb:  return {{24{w[7]}}, w[7:0]};
            ls_pkg::op_lh:  return {{16{w[15]}}, w[15:0]};
            ls_pkg::op_lbu: return {24'b0, w[7:0]};
            ls_pkg::op_lhu: return {16'b0, w[15:0]};
            default:        return w;
        endcase
    endfunction

    function automatic mem_pkg::mem_size_e size_of(ls_pkg::ls_op_e op);
        case (op)
            ls_pkg::op_lb, ls_pkg::op_lbu, ls_pkg::op_sb: return mem_pkg::size_byte;
            ls_pkg::op_lh, ls_pkg::op_lhu, ls_pkg::op_sh: return mem_pkg::size_half;
            default:                                      return mem_pkg::size_word;
        endcase
    endfunction

    assign is_load = req.op inside {ls_pkg::op_lb, ls_pkg::op_lh, ls_pkg::op_lw,
                                    ls_pkg::op_lbu, ls_pkg::op_lhu};
    assign is_store = req.op inside {ls_pkg::op_sb, ls_pkg::op_sh, ls_pkg::op_sw};

    assign cacheable = req.addr < ls_pkg::IO_BASE;
    assign hit       = cacheable && (read_hit || write_hit);
    assign accept    = rdy && ena && (state == idle) && (is_load || is_store);
    assign store_en  = accept && cacheable && write_hit;

    assign busy  = (state != idle) || ena;
    // a held pulse shows once rdy is back
    assign valid = valid_q && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            valid_q <= 1'b0;
            mem_ena <= 1'b0;
        end else if (rdy) begin
            valid_q <= 1'b0;
            mem_ena <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        if (hit) begin
                            valid_q <= is_load;
                        end else begin
                            mem_ena <= 1'b1;
                            state   <= is_load ? wait_load : wait_store;
                        end
                    end
                end
                wait_load: begin
                    // rollback drops the load, late done is ignored in idle
                    if (rollback) begin
                        state <= idle;
                    end else if (mem_done) begin
                        valid_q <= 1'b1;
                        state   <= idle;
                    end
                end
                wait_store: begin
                    if (mem_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && hit && is_load) begin
            result <= extend(req.op, line >> {req.addr[1:0], 3'b000});
        end else if (rdy && state == wait_load && !rollback && mem_done) begin
            result <= extend(load_op, mem_rdata);
        end

        if (accept && !hit) begin
            load_op       <= req.op;
            mem_req.addr  <= req.addr;
            mem_req.wdata <= req.store_value;
            mem_req.write <= is_store;
            mem_req.size  <= size_of(req.op);
        end
    end

endmodule

/* verilog/ls_dcache.sv */
`timescale 1ns/1ps

module ls_dcache (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic [31:0]       addr,
    input  ls_pkg::ls_op_e    op,
    input  logic [31:0]       store_value,
    input  logic              store_en,
    output logic              read_hit,
    output logic              write_hit,
    output logic [31:0]       line
);

    logic [ls_pkg::DCACHE_LINES-1:0] line_valid;
    logic [ls_pkg::DCACHE_TAG_W-1:0] tag_mem [ls_pkg::DCACHE_LINES];
    logic [31:0]                     data_mem [ls_pkg::DCACHE_LINES];

    logic [ls_pkg::DCACHE_INDEX_W-1:0] idx;
    logic [ls_pkg::DCACHE_TAG_W-1:0]   tag;
    logic                              is_load;
    logic                              is_store;
    logic                              tag_match;
    logic [31:0]                       merged;

    assign idx = addr[ls_pkg::DCACHE_TAG_LSB-1:2];
    assign tag = addr[31:ls_pkg::DCACHE_TAG_LSB];

    assign is_load = op inside {ls_pkg::op_lb, ls_pkg::op_lh, ls_pkg::op_lw,
                                ls_pkg::op_lbu, ls_pkg::op_lhu};
    assign is_store = op inside {ls_pkg::op_sb, ls_pkg::op_sh, ls_pkg::op_sw};

    assign tag_match = line_valid[idx] && (tag_mem[idx] == tag);
    assign line      = data_mem[idx];

    assign read_hit = is_load && tag_match;

    // only a full word may claim an empty line, so a valid line never
    // holds bytes that memory has newer copies of
    assign write_hit = is_store && (tag_match || (!line_valid[idx] && op == ls_pkg::op_sw));

    // byte lane merge into the current line
    always_comb begin
        merged = data_mem[idx];
        case (op)
            ls_pkg::op_sb: merged[addr[1:0]*8 +: 8] = store_value[7:0];
            ls_pkg::op_sh: merged[addr[1]*16 +: 16] = store_value[15:0];
            ls_pkg::op_sw: merged = store_value;
            default: merged = data_mem[idx];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else if (rdy && store_en) begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && store_en) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= merged;
        end
    end

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    // value is the number of bytes moved
    typedef enum logic [2:0] {
        size_byte = 3'd1,
        size_half = 3'd2,
        size_word = 3'd4
    } mem_size_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
        mem_size_e   size;
    } mem_req_t;

    // 256 KiB, I/O window included
    localparam int MEM_ADDR_W = 18;

endpackage

/* verilog/ls_pkg.sv */
package ls_pkg;

    // load/store opcodes from the issue buffer
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_lb  = 4'd1,
        op_lh  = 4'd2,
        op_lw  = 4'd3,
        op_lbu = 4'd4,
        op_lhu = 4'd5,
        op_sb  = 4'd6,
        op_sh  = 4'd7,
        op_sw  = 4'd8
    } ls_op_e;

    typedef struct packed {
        ls_op_e      op;
        logic [31:0] addr;
        logic [31:0] store_value;
    } ls_req_t;

    // direct mapped, one word per line
    localparam int DCACHE_LINES   = 64;
    localparam int DCACHE_INDEX_W = $clog2(DCACHE_LINES);
    localparam int DCACHE_TAG_LSB = 2 + DCACHE_INDEX_W;
    localparam int DCACHE_TAG_W   = 32 - DCACHE_TAG_LSB;

    // uncached window starts here
    localparam logic [31:0] IO_BASE = 32'h0003_0000;

endpackage
